// File: rv32_decode_macros.svh
`ifndef RV32_DECODE_MACROS_SVH
`define RV32_DECODE_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Word and field widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define ISA_WIDTH 32

`define FUNCT7_WIDTH 7

`define FUNCT3_WIDTH 3

`define OPCODE_WIDTH 7

`define REG_ADDR_WIDTH 5

// Wide enough for every operation, the invalid code and the three pair candidates.
`define INST_NUM_WIDTH 6

`define CLASS_WIDTH 4

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Least significant bit of each field
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define OPCODE_LSB 0
`define RD_LSB 7
`define FUNCT3_LSB 12
`define RS1_LSB 15
`define RS2_LSB 20
`define FUNCT7_LSB 25

`endif

// File: rv32_decode_pkg.sv
`include "rv32_decode_macros.svh"

package rv32_decode_pkg;

    typedef logic [`ISA_WIDTH-1:0]      inst_t;
    typedef logic [`OPCODE_WIDTH-1:0]   opcode_t;
    typedef logic [`FUNCT3_WIDTH-1:0]   funct3_t;
    typedef logic [`FUNCT7_WIDTH-1:0]   funct7_t;
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [`ISA_WIDTH-1:0]      xlen_t;
    typedef logic [`CLASS_WIDTH-1:0]    class_t;
    typedef logic [`INST_NUM_WIDTH-1:0] inst_num_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Opcode classes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam class_t cls_invalid = `CLASS_WIDTH'd0;
    localparam class_t cls_lui     = `CLASS_WIDTH'd1;
    localparam class_t cls_auipc   = `CLASS_WIDTH'd2;
    localparam class_t cls_jal     = `CLASS_WIDTH'd3;
    localparam class_t cls_jalr    = `CLASS_WIDTH'd4;
    localparam class_t cls_branch  = `CLASS_WIDTH'd5;
    localparam class_t cls_load    = `CLASS_WIDTH'd6;
    localparam class_t cls_store   = `CLASS_WIDTH'd7;
    localparam class_t cls_op_imm  = `CLASS_WIDTH'd8;
    localparam class_t cls_op      = `CLASS_WIDTH'd9;
    localparam class_t cls_system  = `CLASS_WIDTH'd10;

    // funct7 values that pick the base or the alternate operation.
    localparam funct7_t f7_base = 7'b0000000;
    localparam funct7_t f7_alt  = 7'b0100000;

    // The only two system words that decode.
    localparam inst_t word_ecall  = 32'h0000_0073;
    localparam inst_t word_ebreak = 32'h0010_0073;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction numbers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam inst_num_t num_inv    = `INST_NUM_WIDTH'd0;
    localparam inst_num_t num_lui    = `INST_NUM_WIDTH'd1;
    localparam inst_num_t num_auipc  = `INST_NUM_WIDTH'd2;
    localparam inst_num_t num_jal    = `INST_NUM_WIDTH'd3;
    localparam inst_num_t num_jalr   = `INST_NUM_WIDTH'd4;
    localparam inst_num_t num_beq    = `INST_NUM_WIDTH'd5;
    localparam inst_num_t num_bne    = `INST_NUM_WIDTH'd6;
    localparam inst_num_t num_blt    = `INST_NUM_WIDTH'd7;
    localparam inst_num_t num_bge    = `INST_NUM_WIDTH'd8;
    localparam inst_num_t num_bltu   = `INST_NUM_WIDTH'd9;
    localparam inst_num_t num_bgeu   = `INST_NUM_WIDTH'd10;
    localparam inst_num_t num_lb     = `INST_NUM_WIDTH'd11;
    localparam inst_num_t num_lh     = `INST_NUM_WIDTH'd12;
    localparam inst_num_t num_lw     = `INST_NUM_WIDTH'd13;
    localparam inst_num_t num_lbu    = `INST_NUM_WIDTH'd14;
    localparam inst_num_t num_lhu    = `INST_NUM_WIDTH'd15;
    localparam inst_num_t num_sb     = `INST_NUM_WIDTH'd16;
    localparam inst_num_t num_sh     = `INST_NUM_WIDTH'd17;
    localparam inst_num_t num_sw     = `INST_NUM_WIDTH'd18;
    localparam inst_num_t num_addi   = `INST_NUM_WIDTH'd19;
    localparam inst_num_t num_slti   = `INST_NUM_WIDTH'd20;
    localparam inst_num_t num_sltiu  = `INST_NUM_WIDTH'd21;
    localparam inst_num_t num_xori   = `INST_NUM_WIDTH'd22;
    localparam inst_num_t num_ori    = `INST_NUM_WIDTH'd23;
    localparam inst_num_t num_andi   = `INST_NUM_WIDTH'd24;
    localparam inst_num_t num_slli   = `INST_NUM_WIDTH'd25;
    localparam inst_num_t num_srli   = `INST_NUM_WIDTH'd26;
    localparam inst_num_t num_srai   = `INST_NUM_WIDTH'd27;
    localparam inst_num_t num_add    = `INST_NUM_WIDTH'd28;
    localparam inst_num_t num_sub    = `INST_NUM_WIDTH'd29;
    localparam inst_num_t num_sll    = `INST_NUM_WIDTH'd30;
    localparam inst_num_t num_slt    = `INST_NUM_WIDTH'd31;
    localparam inst_num_t num_sltu   = `INST_NUM_WIDTH'd32;
    localparam inst_num_t num_xor    = `INST_NUM_WIDTH'd33;
    localparam inst_num_t num_srl    = `INST_NUM_WIDTH'd34;
    localparam inst_num_t num_sra    = `INST_NUM_WIDTH'd35;
    localparam inst_num_t num_or     = `INST_NUM_WIDTH'd36;
    localparam inst_num_t num_and    = `INST_NUM_WIDTH'd37;
    localparam inst_num_t num_ecall  = `INST_NUM_WIDTH'd38;
    localparam inst_num_t num_ebreak = `INST_NUM_WIDTH'd39;

    // Candidates that only funct7 can settle. They never leave the unit.
    localparam inst_num_t num_srli_srai = `INST_NUM_WIDTH'd40;
    localparam inst_num_t num_add_sub   = `INST_NUM_WIDTH'd41;
    localparam inst_num_t num_srl_sra   = `INST_NUM_WIDTH'd42;

endpackage

// File: idu_imm.sv
`timescale 1ns/1ns
`include "rv32_decode_macros.svh"

module idu_imm (
    input  rv32_decode_pkg::inst_t  inst,
    input  rv32_decode_pkg::class_t inst_class,
    output rv32_decode_pkg::xlen_t  imm
);

    import rv32_decode_pkg::*;

    xlen_t imm_i;
    xlen_t imm_s;
    xlen_t imm_b;
    xlen_t imm_u;
    xlen_t imm_j;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Format assembly with the sign taken from inst[31]
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Shift amounts ride along in the low bits of the I value.
    assign imm_i = {{20{inst[31]}}, inst[31:20]};

    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};

    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    assign imm_u = {inst[31:12], 12'b0};

    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (inst_class)
            cls_jalr,
            cls_load,
            cls_op_imm,
            cls_system: imm = imm_i;
            cls_store:  imm = imm_s;
            cls_branch: imm = imm_b;
            cls_lui,
            cls_auipc:  imm = imm_u;
            cls_jal:    imm = imm_j;
            default:    imm = '0; // Register ALU operations carry no immediate.
        endcase
    end

endmodule

// File: idu_opcode.sv
`timescale 1ns/1ns
`include "rv32_decode_macros.svh"

module idu_opcode (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    inst_valid,
    input  rv32_decode_pkg::inst_t  inst,
    output logic                    s1_valid,
    output rv32_decode_pkg::inst_t  s1_inst,
    output rv32_decode_pkg::class_t s1_class
);

    import rv32_decode_pkg::*;

    opcode_t opcode;
    class_t  class_next;

    assign opcode = inst[`OPCODE_LSB +: `OPCODE_WIDTH];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Opcode to class
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (opcode)
            7'b0110111: class_next = cls_lui;
            7'b0010111: class_next = cls_auipc;
            7'b1101111: class_next = cls_jal;
            7'b1100111: class_next = cls_jalr;
            7'b1100011: class_next = cls_branch;
            7'b0000011: class_next = cls_load;
            7'b0100011: class_next = cls_store;
            7'b0010011: class_next = cls_op_imm;
            7'b0110011: class_next = cls_op;
            7'b1110011: class_next = cls_system; // CSR words also land here and fail later.
            default:    class_next = cls_invalid; // Fence and reserved opcodes.
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= inst_valid;
        end
    end

    // Payload only moves on a strobe.
    always_ff @(posedge clk) begin
        if (inst_valid) begin
            s1_inst  <= inst;
            s1_class <= class_next;
        end
    end

    // An undriven word here would turn into an unknown number three cycles later.
    assert property (@(posedge clk) disable iff (reset) inst_valid |-> !$isunknown(inst))
        else $error("idu_opcode: inst has unknown bits while inst_valid is high.");

endmodule

// File: idu_funct3.sv
`timescale 1ns/1ns
`include "rv32_decode_macros.svh"

module idu_funct3 (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       s1_valid,
    input  rv32_decode_pkg::inst_t     s1_inst,
    input  rv32_decode_pkg::class_t    s1_class,
    output logic                       s2_valid,
    output rv32_decode_pkg::inst_t     s2_inst,
    output rv32_decode_pkg::class_t    s2_class,
    output rv32_decode_pkg::inst_num_t s2_cand
);

    import rv32_decode_pkg::*;

    funct3_t   funct3;
    inst_num_t cand_next;

    assign funct3 = s1_inst[`FUNCT3_LSB +: `FUNCT3_WIDTH];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Candidate selection by class and funct3
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        cand_next = num_inv; // Holes in the funct3 tables fall through to this.
        case (s1_class)
            cls_lui:    cand_next = num_lui;
            cls_auipc:  cand_next = num_auipc;
            cls_jal:    cand_next = num_jal;
            cls_jalr:   cand_next = (funct3 == 3'b000) ? num_jalr : num_inv;
            cls_system: cand_next = num_ecall; // Settled by full word in stage three.
            cls_branch: begin
                case (funct3)
                    3'b000:  cand_next = num_beq;
                    3'b001:  cand_next = num_bne;
                    3'b100:  cand_next = num_blt;
                    3'b101:  cand_next = num_bge;
                    3'b110:  cand_next = num_bltu;
                    3'b111:  cand_next = num_bgeu;
                    default: cand_next = num_inv;
                endcase
            end
            cls_load: begin
                case (funct3)
                    3'b000:  cand_next = num_lb;
                    3'b001:  cand_next = num_lh;
                    3'b010:  cand_next = num_lw;
                    3'b100:  cand_next = num_lbu;
                    3'b101:  cand_next = num_lhu;
                    default: cand_next = num_inv;
                endcase
            end
            cls_store: begin
                case (funct3)
                    3'b000:  cand_next = num_sb;
                    3'b001:  cand_next = num_sh;
                    3'b010:  cand_next = num_sw;
                    default: cand_next = num_inv;
                endcase
            end
            cls_op_imm: begin
                case (funct3)
                    3'b000: cand_next = num_addi;
                    3'b001: cand_next = num_slli;
                    3'b010: cand_next = num_slti;
                    3'b011: cand_next = num_sltiu;
                    3'b100: cand_next = num_xori;
                    3'b101: cand_next = num_srli_srai;
                    3'b110: cand_next = num_ori;
                    3'b111: cand_next = num_andi;
                endcase
            end
            cls_op: begin
                case (funct3)
                    3'b000: cand_next = num_add_sub;
                    3'b001: cand_next = num_sll;
                    3'b010: cand_next = num_slt;
                    3'b011: cand_next = num_sltu;
                    3'b100: cand_next = num_xor;
                    3'b101: cand_next = num_srl_sra;
                    3'b110: cand_next = num_or;
                    3'b111: cand_next = num_and;
                endcase
            end
            default: cand_next = num_inv;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            s2_inst  <= s1_inst;
            s2_class <= s1_class;
            s2_cand  <= cand_next;
        end
    end

endmodule

// File: idu_funct7.sv
`timescale 1ns/1ns
`include "rv32_decode_macros.svh"

module idu_funct7 (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       s2_valid,
    input  rv32_decode_pkg::inst_t     s2_inst,
    input  rv32_decode_pkg::class_t    s2_class,
    input  rv32_decode_pkg::inst_num_t s2_cand,
    output logic                       dec_valid,
    output rv32_decode_pkg::inst_num_t inst_num,
    output rv32_decode_pkg::reg_addr_t rd,
    output rv32_decode_pkg::reg_addr_t rs1,
    output rv32_decode_pkg::reg_addr_t rs2,
    output rv32_decode_pkg::xlen_t     imm
);

    import rv32_decode_pkg::*;

    funct7_t   funct7;
    inst_num_t num_next;
    xlen_t     imm_next;

    assign funct7 = s2_inst[`FUNCT7_LSB +: `FUNCT7_WIDTH];

    idu_imm u_imm (
        .inst      (s2_inst),
        .inst_class(s2_class),
        .imm       (imm_next)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Final resolution
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (s2_cand)
            num_srli_srai: begin
                if (funct7 == f7_base) begin
                    num_next = num_srli;
                end else if (funct7 == f7_alt) begin
                    num_next = num_srai;
                end else begin
                    num_next = num_inv;
                end
            end
            num_add_sub: begin
                if (funct7 == f7_base) begin
                    num_next = num_add;
                end else if (funct7 == f7_alt) begin
                    num_next = num_sub;
                end else begin
                    num_next = num_inv;
                end
            end
            num_srl_sra: begin
                if (funct7 == f7_base) begin
                    num_next = num_srl;
                end else if (funct7 == f7_alt) begin
                    num_next = num_sra;
                end else begin
                    num_next = num_inv;
                end
            end
            // No alternate form exists for these.
            num_slli, num_sll, num_slt, num_sltu, num_xor, num_or, num_and:
                num_next = (funct7 == f7_base) ? s2_cand : num_inv;
            num_ecall: begin
                if (s2_inst == word_ecall) begin
                    num_next = num_ecall;
                end else if (s2_inst == word_ebreak) begin
                    num_next = num_ebreak;
                end else begin
                    num_next = num_inv; // CSR access and anything else in the system space.
                end
            end
            default: num_next = s2_cand;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s2_valid) begin
            inst_num <= num_next;
            rd       <= s2_inst[`RD_LSB +: `REG_ADDR_WIDTH];
            rs1      <= s2_inst[`RS1_LSB +: `REG_ADDR_WIDTH];
            rs2      <= s2_inst[`RS2_LSB +: `REG_ADDR_WIDTH];
            imm      <= imm_next;
        end
    end

    assert property (@(posedge clk) disable iff (reset) dec_valid |-> !$isunknown(inst_num))
        else $error("idu_funct7: inst_num is unknown while dec_valid is high.");

endmodule

// File: idu_top.sv
`timescale 1ns/1ns
`include "rv32_decode_macros.svh"

module idu_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       inst_valid,
    input  rv32_decode_pkg::inst_t     inst,
    output logic                       dec_valid,
    output rv32_decode_pkg::inst_num_t inst_num,
    output rv32_decode_pkg::reg_addr_t rd,
    output rv32_decode_pkg::reg_addr_t rs1,
    output rv32_decode_pkg::reg_addr_t rs2,
    output rv32_decode_pkg::xlen_t     imm
);

    import rv32_decode_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage to stage wires
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic      s1_valid;
    inst_t     s1_inst;
    class_t    s1_class;
    logic      s2_valid;
    inst_t     s2_inst;
    class_t    s2_class;
    inst_num_t s2_cand;

    idu_opcode uut_opcode (
        .clk       (clk),
        .reset     (reset),
        .inst_valid(inst_valid),
        .inst      (inst),
        .s1_valid  (s1_valid),
        .s1_inst   (s1_inst),
        .s1_class  (s1_class)
    );

    idu_funct3 uut_funct3 (
        .clk     (clk),
        .reset   (reset),
        .s1_valid(s1_valid),
        .s1_inst (s1_inst),
        .s1_class(s1_class),
        .s2_valid(s2_valid),
        .s2_inst (s2_inst),
        .s2_class(s2_class),
        .s2_cand (s2_cand)
    );

    // Last stage also owns the immediate generator.
    idu_funct7 uut_funct7 (
        .clk      (clk),
        .reset    (reset),
        .s2_valid (s2_valid),
        .s2_inst  (s2_inst),
        .s2_class (s2_class),
        .s2_cand  (s2_cand),
        .dec_valid(dec_valid),
        .inst_num (inst_num),
        .rd       (rd),
        .rs1      (rs1),
        .rs2      (rs2),
        .imm      (imm)
    );

endmodule

// File: tb_idu_top.sv
`timescale 1ns/1ns
`include "rv32_decode_macros.svh"

module tb_idu_top;

    import rv32_decode_pkg::*;

    localparam int cycle_limit = 4000; // About twice the cycles the tests use.

    logic      clk = 1'b0;
    logic      reset;
    logic      inst_valid;
    inst_t     inst;
    logic      dec_valid;
    inst_num_t inst_num;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    xlen_t     imm;

    int    seed = 11148;
    int    cycle = 0;
    int    errors = 0;
    int    checked = 0;
    inst_t pend_word[$];
    int    pend_cycle[$];

    idu_top uut (
        .clk       (clk),
        .reset     (reset),
        .inst_valid(inst_valid),
        .inst      (inst),
        .dec_valid (dec_valid),
        .inst_num  (inst_num),
        .rd        (rd),
        .rs1       (rs1),
        .rs2       (rs2),
        .imm       (imm)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    // Watchdog on the posedge count.
    initial begin
        while (cycle < cycle_limit) begin
            @(posedge clk);
            cycle = cycle + 1;
        end
        $display("Timeout: the run hung and did not finish within %0d cycles.", cycle_limit);
        $display("TB FAILED");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference decoder
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic inst_num_t expected_num(input inst_t w);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = w[14:12];
        f7 = w[31:25];
        expected_num = num_inv;
        case (w[6:0])
            7'b0110111: expected_num = num_lui;
            7'b0010111: expected_num = num_auipc;
            7'b1101111: expected_num = num_jal;
            7'b1100111: if (f3 == 3'd0) expected_num = num_jalr;
            7'b1100011: begin
                if (f3 == 3'd0) expected_num = num_beq;
                if (f3 == 3'd1) expected_num = num_bne;
                if (f3 == 3'd4) expected_num = num_blt;
                if (f3 == 3'd5) expected_num = num_bge;
                if (f3 == 3'd6) expected_num = num_bltu;
                if (f3 == 3'd7) expected_num = num_bgeu;
            end
            7'b0000011: begin
                if (f3 == 3'd0) expected_num = num_lb;
                if (f3 == 3'd1) expected_num = num_lh;
                if (f3 == 3'd2) expected_num = num_lw;
                if (f3 == 3'd4) expected_num = num_lbu;
                if (f3 == 3'd5) expected_num = num_lhu;
            end
            7'b0100011: begin
                if (f3 == 3'd0) expected_num = num_sb;
                if (f3 == 3'd1) expected_num = num_sh;
                if (f3 == 3'd2) expected_num = num_sw;
            end
            7'b0010011: begin
                if (f3 == 3'd0) expected_num = num_addi;
                if (f3 == 3'd2) expected_num = num_slti;
                if (f3 == 3'd3) expected_num = num_sltiu;
                if (f3 == 3'd4) expected_num = num_xori;
                if (f3 == 3'd6) expected_num = num_ori;
                if (f3 == 3'd7) expected_num = num_andi;
                if (f3 == 3'd1 && f7 == 7'h00) expected_num = num_slli;
                if (f3 == 3'd5 && f7 == 7'h00) expected_num = num_srli;
                if (f3 == 3'd5 && f7 == 7'h20) expected_num = num_srai;
            end
            7'b0110011: begin
                if (f7 == 7'h20 && f3 == 3'd0) expected_num = num_sub;
                if (f7 == 7'h20 && f3 == 3'd5) expected_num = num_sra;
                if (f7 == 7'h00) begin
                    case (f3)
                        3'd0: expected_num = num_add;
                        3'd1: expected_num = num_sll;
                        3'd2: expected_num = num_slt;
                        3'd3: expected_num = num_sltu;
                        3'd4: expected_num = num_xor;
                        3'd5: expected_num = num_srl;
                        3'd6: expected_num = num_or;
                        3'd7: expected_num = num_and;
                    endcase
                end
            end
            7'b1110011: begin
                if (w == 32'h0000_0073) expected_num = num_ecall;
                if (w == 32'h0010_0073) expected_num = num_ebreak;
            end
            default: expected_num = num_inv;
        endcase
    endfunction

    function automatic xlen_t expected_imm(input inst_t w);
        case (w[6:0])
            7'b1100111, 7'b0000011, 7'b0010011, 7'b1110011:
                expected_imm = $signed(w[31:20]);
            7'b0100011: expected_imm = $signed({w[31:25], w[11:7]});
            7'b1100011: expected_imm = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0});
            7'b0110111, 7'b0010111: expected_imm = {w[31:12], 12'h000};
            7'b1101111: expected_imm = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0});
            default: expected_imm = 32'h0; // Register ops and unknown opcodes.
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus and checking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [6:0] opcode_at(input int pick);
        case (pick)
            0:       opcode_at = 7'b0110111;
            1:       opcode_at = 7'b0010111;
            2:       opcode_at = 7'b1101111;
            3:       opcode_at = 7'b1100111;
            4:       opcode_at = 7'b1100011;
            5:       opcode_at = 7'b0000011;
            6:       opcode_at = 7'b0100011;
            7:       opcode_at = 7'b0010011;
            8:       opcode_at = 7'b0110011;
            default: opcode_at = 7'b1110011;
        endcase
    endfunction

    task automatic make_word(input int rand_in_8, output inst_t w);
        int pick;
        int sel;
        w = $random(seed);
        if ({$random(seed)} % 8 >= rand_in_8) begin // Otherwise keep the raw random word.
            pick = {$random(seed)} % 10;
            sel = {$random(seed)} % 5;
            w[6:0] = opcode_at(pick);
            if (pick == 3 && sel < 4) w[14:12] = 3'd0;
            if ((pick == 7 || pick == 8) && sel < 2) w[31:25] = 7'h00;
            if ((pick == 7 || pick == 8) && (sel == 2 || sel == 3)) w[31:25] = 7'h20;
            if (pick == 9 && sel < 2) w = 32'h0000_0073;
            if (pick == 9 && (sel == 2 || sel == 3)) w = 32'h0010_0073;
        end
    endtask

    task automatic report_error(input string test, input string field,
                                input logic [31:0] exp, input logic [31:0] act,
                                input inst_t w);
        $display("Error %s: %s expected %h actual %h (inst %h)", test, field, exp, act, w);
        errors = errors + 1;
    endtask

    task automatic check_outputs(input string test);
        inst_t w;
        int    c;
        if (reset) begin
            if (dec_valid !== 1'b0) begin
                $display("Error %s: dec_valid is high while reset is held.", test);
                errors = errors + 1;
            end
        end else if (dec_valid === 1'b1) begin
            if (pend_word.size() == 0) begin
                $display("Error %s: dec_valid is high with no instruction in flight.", test);
                errors = errors + 1;
            end else begin
                w = pend_word.pop_front();
                c = pend_cycle.pop_front();
                checked = checked + 1;
                if (cycle - c != 3) report_error(test, "latency", 3, cycle - c, w);
                if (inst_num !== expected_num(w)) begin
                    report_error(test, "inst_num", expected_num(w), inst_num, w);
                end
                if (rd !== w[11:7]) report_error(test, "rd", w[11:7], rd, w);
                if (rs1 !== w[19:15]) report_error(test, "rs1", w[19:15], rs1, w);
                if (rs2 !== w[24:20]) report_error(test, "rs2", w[24:20], rs2, w);
                if (imm !== expected_imm(w)) report_error(test, "imm", expected_imm(w), imm, w);
            end
        end
    endtask

    // One cycle. Outputs are checked at the falling edge, then new inputs go out.
    task automatic step(input string test, input logic valid, input inst_t w);
        @(negedge clk);
        check_outputs(test);
        inst_valid = valid;
        inst = w;
        if (valid) begin
            pend_word.push_back(w);
            pend_cycle.push_back(cycle);
        end
    endtask

    task automatic run_test(input string test, input int steps, input int valid_pct,
                            input int rand_in_8);
        int    err0;
        int    chk0;
        int    waited;
        inst_t w;
        err0 = errors;
        chk0 = checked;
        waited = 0;
        for (int i = 0; i < steps; i++) begin
            make_word(rand_in_8, w);
            step(test, ({$random(seed)} % 100) < valid_pct, w);
        end
        while (pend_word.size() > 0 && waited < 8) begin
            step(test, 1'b0, 32'h0);
            waited = waited + 1;
        end
        if (pend_word.size() > 0) begin
            $display("Error %s: %0d results never left the pipeline.", test, pend_word.size());
            errors = errors + 1;
            pend_word.delete();
            pend_cycle.delete();
        end
        $display("Test %s: %0d results checked, %0d errors", test, checked - chk0,
                 errors - err0);
    endtask

    initial begin
        reset = 1'b1;
        inst_valid = 1'b0;
        inst = 32'h0;
        repeat (4) step("reset", 1'b0, 32'h0);
        reset = 1'b0;
        $display("Test reset: %0d errors", errors);
        run_test("random_mix", 1200, 70, 1);
        run_test("back_to_back", 300, 100, 1);
        run_test("invalid_heavy", 300, 70, 4); // Half the words are raw random.
        $display("Tests 4, results checked %0d, errors %0d", checked, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: idu_top.f
+incdir+.
rv32_decode_pkg.sv
idu_imm.sv
idu_opcode.sv
idu_funct3.sv
idu_funct7.sv
idu_top.sv
tb_idu_top.sv

// File: Bender.yml
package:
  name: idu_top

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - rv32_decode_pkg.sv
      - idu_imm.sv
      - idu_opcode.sv
      - idu_funct3.sv
      - idu_funct7.sv
      - idu_top.sv
  - target: test
    files:
      - tb_idu_top.sv
